// File: procIsa_pkg.sv
// Instruction set definitions for the 16-bit five-stage processor
// Word and register index types
// Opcode and ALU operation enums
// Instruction field positions and widths
// Instruction and data memory sizes
package procIsa_pkg;

    localparam int WordW = 16;
    localparam int RegW = 3;
    localparam int NumRegs = 8;
    localparam int OpW = 4;

    // LSB of each instruction field
    localparam int OpPos = 12;
    localparam int RdPos = 9;
    localparam int RsPos = 6;
    localparam int RtPos = 3;
    localparam int ImmPos = 0;

    // I-format immediate and branch offset widths
    localparam int ImmW = 6;
    localparam int OffW = 9;

    localparam int ImemDepth = 256;
    localparam int DmemDepth = 256;
    localparam int ImemAddrW = 8;
    localparam int DmemAddrW = 8;

    typedef logic [WordW-1:0] wordT;
    typedef logic [RegW-1:0] regAddrT;

    // Encodings 10 to 15 are undefined
    typedef enum logic [OpW-1:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opXor  = 4'd3,
        opAddi = 4'd4,
        opLd   = 4'd5,
        opSt   = 4'd6,
        opBeqz = 4'd7,
        opBnez = 4'd8,
        opHalt = 4'd9
    } opcodeT;

    // Same order as the R-format opcodes
    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluXor = 2'd3
    } aluOpT;

endpackage

// File: procPipe_pkg.sv
// Pipeline definitions for the 16-bit five-stage processor
// Control word and the four pipeline register structs
// Forward select codes
// Source register helpers shared by decode and hazard logic
package procPipe_pkg;
    import procIsa_pkg::*;

    localparam logic [1:0] FwdReg = 2'd0;
    localparam logic [1:0] FwdExMem = 2'd1;
    localparam logic [1:0] FwdMemWb = 2'd2;

    typedef struct packed {
        aluOpT aluOp;
        logic  useImm;
        logic  readRs;
        logic  readRt;
        logic  memRead;
        logic  memWrite;
        logic  regWrite;
        logic  branchZero;
        logic  branchNonZero;
        logic  halt;
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic    valid;
        wordT    pc;
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        wordT    rsVal;
        wordT    rtVal;
        wordT    imm;
    } idExT;

    typedef struct packed {
        logic    valid;
        ctrlT    ctrl;
        regAddrT rd;
        wordT    aluRes;
        wordT    storeVal;
    } exMemT;

    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    halt;
        regAddrT rd;
        wordT    data;
    } memWbT;

    // Branches test the register held in the rd slot
    function automatic regAddrT srcRs(input wordT instr, input ctrlT ctrl);
        return (ctrl.branchZero || ctrl.branchNonZero) ? instr[RdPos +: RegW]
                                                       : instr[RsPos +: RegW];
    endfunction

    // Stores take their data from the rd slot
    function automatic regAddrT srcRt(input wordT instr, input ctrlT ctrl);
        return ctrl.memWrite ? instr[RdPos +: RegW] : instr[RtPos +: RegW];
    endfunction

endpackage

// File: fetch.sv
`timescale 1ns/1ps
// Instruction fetch stage
// Program counter with branch redirect and halt freeze
// Instruction memory with a write port for program loading
// IF/ID pipeline register with stall hold
module fetch import procIsa_pkg::*, procPipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 branchTaken,
    input  wordT                 branchTarget,
    input  logic                 haltSeen,
    input  logic                 imemWrEn,
    input  logic [ImemAddrW-1:0] imemWrAddr,
    input  wordT                 imemWrData,
    output ifIdT                 ifId
);

    wordT pc;
    wordT instr;
    wordT imem [ImemDepth];

    // Program load port
    always_ff @(posedge clk) begin
        if (imemWrEn) begin
            imem[imemWrAddr] <= imemWrData;
        end
    end

    assign instr = imem[pc[ImemAddrW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall && !haltSeen) begin
            pc <= pc + 16'd1;
        end
    end

    // Wrong-path fetch is dropped on a taken branch
    always_ff @(posedge clk) begin
        if (rst) begin
            ifId.valid <= 1'b0;
        end else if (branchTaken || haltSeen) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.valid <= 1'b1;
            ifId.pc <= pc;
            ifId.instr <= instr;
        end
    end

endmodule

// File: decode.sv
`timescale 1ns/1ps
// Instruction decode stage
// Eight-entry register file with r0 tied to zero
// Write-back bypass on both read ports
// Immediate and branch offset sign extension
// ID/EX pipeline register with bubble insert
module decode import procIsa_pkg::*, procPipe_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  ifIdT  ifId,
    input  ctrlT  decCtrl,
    input  logic  stall,
    input  logic  flush,
    input  memWbT memWb,
    output idExT  idEx
);

    wordT    regFile [NumRegs];
    regAddrT rsAddr;
    regAddrT rtAddr;
    regAddrT rdAddr;
    wordT    rsVal;
    wordT    rtVal;
    wordT    imm;
    logic    wbEn;

    assign rsAddr = srcRs(ifId.instr, decCtrl);
    assign rtAddr = srcRt(ifId.instr, decCtrl);
    assign rdAddr = ifId.instr[RdPos +: RegW];
    assign wbEn = memWb.valid && memWb.regWrite && (memWb.rd != '0);

    always_ff @(posedge clk) begin
        if (wbEn) begin
            regFile[memWb.rd] <= memWb.data;
        end
    end

    // Reads see the value being written this cycle
    always_comb begin
        rsVal = regFile[rsAddr];
        if (rsAddr == '0) begin
            rsVal = '0;
        end else if (wbEn && (memWb.rd == rsAddr)) begin
            rsVal = memWb.data;
        end
        rtVal = regFile[rtAddr];
        if (rtAddr == '0) begin
            rtVal = '0;
        end else if (wbEn && (memWb.rd == rtAddr)) begin
            rtVal = memWb.data;
        end
    end

    always_comb begin
        if (decCtrl.branchZero || decCtrl.branchNonZero) begin
            imm = {{(WordW-OffW){ifId.instr[ImmPos+OffW-1]}}, ifId.instr[ImmPos +: OffW]};
        end else begin
            imm = {{(WordW-ImmW){ifId.instr[ImmPos+ImmW-1]}}, ifId.instr[ImmPos +: ImmW]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= ifId.valid && !stall && !flush;
            idEx.pc <= ifId.pc;
            idEx.ctrl <= decCtrl;
            idEx.rs <= rsAddr;
            idEx.rt <= rtAddr;
            idEx.rd <= rdAddr;
            idEx.rsVal <= rsVal;
            idEx.rtVal <= rtVal;
            idEx.imm <= imm;
        end
    end

endmodule

// File: pipeControl.sv
`timescale 1ns/1ps
// Pipeline control
// Opcode decode into the control word
// Load-use stall and forward source selection
// Flush on taken branch and while a HALT drains
// Sticky halted and error flags
module pipeControl import procIsa_pkg::*, procPipe_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ifIdT       ifId,
    input  idExT       idEx,
    input  exMemT      exMem,
    input  memWbT      memWb,
    input  logic       branchTaken,
    output ctrlT       decCtrl,
    output logic       stall,
    output logic       flush,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB,
    output logic       halted,
    output logic       err
);

    opcodeT  opcode;
    logic    undefOp;
    regAddrT ifRs;
    regAddrT ifRt;
    logic    loadUse;
    logic    haltRetire;
    logic    haltInFlight;
    logic    haltReg;
    logic    errNow;
    logic    errReg;

    // Younger producer wins, r0 never forwarded
    function automatic logic [1:0] fwdSel(input regAddrT src, input exMemT em,
                                          input memWbT mw);
        if (src == '0) begin
            return FwdReg;
        end
        if (em.valid && em.ctrl.regWrite && !em.ctrl.memRead && (em.rd == src)) begin
            return FwdExMem;
        end
        if (mw.valid && mw.regWrite && (mw.rd == src)) begin
            return FwdMemWb;
        end
        return FwdReg;
    endfunction

    assign opcode = opcodeT'(ifId.instr[OpPos +: OpW]);

    always_comb begin
        decCtrl = '0;
        undefOp = 1'b0;
        case (opcode)
            opAdd, opSub, opAnd, opXor: begin
                // R-format low bits are the ALU encoding
                decCtrl.aluOp = aluOpT'(opcode[1:0]);
                decCtrl.readRs = 1'b1;
                decCtrl.readRt = 1'b1;
                decCtrl.regWrite = 1'b1;
            end
            opAddi: begin
                decCtrl.useImm = 1'b1;
                decCtrl.readRs = 1'b1;
                decCtrl.regWrite = 1'b1;
            end
            opLd: begin
                decCtrl.useImm = 1'b1;
                decCtrl.readRs = 1'b1;
                decCtrl.memRead = 1'b1;
                decCtrl.regWrite = 1'b1;
            end
            opSt: begin
                decCtrl.useImm = 1'b1;
                decCtrl.readRs = 1'b1;
                decCtrl.readRt = 1'b1;
                decCtrl.memWrite = 1'b1;
            end
            opBeqz: begin
                decCtrl.readRs = 1'b1;
                decCtrl.branchZero = 1'b1;
            end
            opBnez: begin
                decCtrl.readRs = 1'b1;
                decCtrl.branchNonZero = 1'b1;
            end
            opHalt: decCtrl.halt = 1'b1;
            default: undefOp = 1'b1;
        endcase
    end

    // Load in EX feeding the instruction in decode
    assign ifRs = srcRs(ifId.instr, decCtrl);
    assign ifRt = srcRt(ifId.instr, decCtrl);
    assign loadUse = ifId.valid && idEx.valid && idEx.ctrl.memRead && (idEx.rd != '0) &&
                     ((decCtrl.readRs && (idEx.rd == ifRs)) ||
                      (decCtrl.readRt && (idEx.rd == ifRt)));

    always_comb begin
        fwdA = fwdSel(idEx.rs, exMem, memWb);
        fwdB = fwdSel(idEx.rt, exMem, memWb);
    end

    // Everything behind a HALT is squashed until reset
    assign haltRetire = memWb.valid && memWb.halt;
    assign haltInFlight = (idEx.valid && idEx.ctrl.halt) ||
                          (exMem.valid && exMem.ctrl.halt) || haltRetire;
    assign flush = branchTaken || haltInFlight || haltReg;
    assign stall = loadUse && !flush;
    assign halted = haltReg || haltRetire;

    assign errNow = ifId.valid && undefOp && !flush;
    assign err = errReg || errNow;

    always_ff @(posedge clk) begin
        if (rst) begin
            haltReg <= 1'b0;
            errReg <= 1'b0;
        end else begin
            if (haltRetire) begin
                haltReg <= 1'b1;
            end
            if (errNow) begin
                errReg <= 1'b1;
            end
        end
    end

endmodule

// File: execute.sv
`timescale 1ns/1ps
// Execute stage
// Operand forwarding muxes
// ALU with add, subtract, and, xor
// Zero-test branch resolution and target
// EX/MEM pipeline register
module execute import procIsa_pkg::*, procPipe_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  idExT       idEx,
    input  logic [1:0] fwdA,
    input  logic [1:0] fwdB,
    input  wordT       exMemFwd,
    input  wordT       memWbFwd,
    output exMemT      exMem,
    output logic       branchTaken,
    output wordT       branchTarget
);

    wordT opA;
    wordT rtFwd;
    wordT opB;
    wordT aluRes;

    function automatic wordT fwdMux(input logic [1:0] sel, input wordT regVal,
                                    input wordT emVal, input wordT mwVal);
        case (sel)
            FwdExMem: return emVal;
            FwdMemWb: return mwVal;
            default:  return regVal;
        endcase
    endfunction

    always_comb begin
        opA = fwdMux(fwdA, idEx.rsVal, exMemFwd, memWbFwd);
        rtFwd = fwdMux(fwdB, idEx.rtVal, exMemFwd, memWbFwd);
    end

    assign opB = idEx.ctrl.useImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub:  aluRes = opA - opB;
            aluAnd:  aluRes = opA & opB;
            aluXor:  aluRes = opA ^ opB;
            default: aluRes = opA + opB;
        endcase
    end

    // Resolved on the forwarded rs value
    assign branchTaken = idEx.valid &&
                         ((idEx.ctrl.branchZero && (opA == '0)) ||
                          (idEx.ctrl.branchNonZero && (opA != '0)));
    assign branchTarget = idEx.pc + 16'd1 + idEx.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl <= idEx.ctrl;
            exMem.rd <= idEx.rd;
            exMem.aluRes <= aluRes;
            exMem.storeVal <= rtFwd;
        end
    end

endmodule

// File: memStage.sv
`timescale 1ns/1ps
// Memory stage
// Word-addressed data memory with combinational read
// Write-back data select
// MEM/WB pipeline register
module memStage import procIsa_pkg::*, procPipe_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  exMemT exMem,
    output memWbT memWb
);

    wordT                 dmem [DmemDepth];
    logic [DmemAddrW-1:0] addr;
    wordT                 loadData;

    assign addr = exMem.aluRes[DmemAddrW-1:0];
    assign loadData = dmem[addr];

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.ctrl.memWrite) begin
            dmem[addr] <= exMem.storeVal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb.valid <= 1'b0;
        end else begin
            memWb.valid <= exMem.valid;
            // Writes to r0 are dropped here
            memWb.regWrite <= exMem.ctrl.regWrite && (exMem.rd != '0);
            memWb.halt <= exMem.ctrl.halt;
            memWb.rd <= exMem.rd;
            memWb.data <= exMem.ctrl.memRead ? loadData : exMem.aluRes;
        end
    end

endmodule

// File: proc.sv
`timescale 1ns/1ps
// Top level of the five-stage 16-bit processor
// Fetch, decode, execute and memory stages with pipeline control
// Retire outputs taken from the MEM/WB register
module proc import procIsa_pkg::*, procPipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 imemWrEn,
    input  logic [ImemAddrW-1:0] imemWrAddr,
    input  wordT                 imemWrData,
    output logic                 retireValid,
    output regAddrT              retireRd,
    output wordT                 retireData,
    output logic                 retireWrite,
    output logic                 halted,
    output logic                 err
);

    ifIdT       ifId;
    idExT       idEx;
    exMemT      exMem;
    memWbT      memWb;
    ctrlT       decCtrl;
    logic       stall;
    logic       flush;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic       branchTaken;
    wordT       branchTarget;

    fetch fetch0 (.clk(clk), .rst(rst), .stall(stall), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .haltSeen(halted), .imemWrEn(imemWrEn),
        .imemWrAddr(imemWrAddr), .imemWrData(imemWrData), .ifId(ifId));

    decode decode0 (.clk(clk), .rst(rst), .ifId(ifId), .decCtrl(decCtrl), .stall(stall),
        .flush(flush), .memWb(memWb), .idEx(idEx));

    pipeControl control0 (.clk(clk), .rst(rst), .ifId(ifId), .idEx(idEx), .exMem(exMem),
        .memWb(memWb), .branchTaken(branchTaken), .decCtrl(decCtrl), .stall(stall),
        .flush(flush), .fwdA(fwdA), .fwdB(fwdB), .halted(halted), .err(err));

    execute exec0 (.clk(clk), .rst(rst), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .exMemFwd(exMem.aluRes), .memWbFwd(memWb.data), .exMem(exMem),
        .branchTaken(branchTaken), .branchTarget(branchTarget));

    memStage mem0 (.clk(clk), .rst(rst), .exMem(exMem), .memWb(memWb));

    // Retirement is the MEM/WB entry seen by the register file
    assign retireValid = memWb.valid;
    assign retireRd = memWb.rd;
    assign retireData = memWb.data;
    assign retireWrite = memWb.valid && memWb.regWrite;

endmodule

// File: proc_assert.sv
`timescale 1ns/1ps
// Concurrent checks on the processor retire and status outputs
// Bound into every proc instance
module proc_assert import procIsa_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    retireValid,
    input regAddrT retireRd,
    input wordT    retireData,
    input logic    retireWrite,
    input logic    halted,
    input logic    err
);

    int failCount = 0;

    // Nothing retires once HALT has retired
    noRetireAfterHalt: assert property (@(posedge clk) disable iff (rst)
        halted |=> !retireValid)
        else begin
            failCount++;
            $error("retirement seen after halted");
        end

    haltedSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped before reset");
        end

    errSticky: assert property (@(posedge clk) disable iff (rst) err |=> err)
        else begin
            failCount++;
            $error("err dropped before reset");
        end

    // Retirements to r0 never carry write data
    r0Quiet: assert property (@(posedge clk) disable iff (rst)
        (retireValid && (retireRd == '0)) |-> (!retireWrite || (retireData == '0)))
        else begin
            failCount++;
            $error("nonzero data retired to r0");
        end

endmodule

bind proc proc_assert procChecks (.*);

// File: proc_tb.sv
`timescale 1ns/1ps
// Testbench for the five-stage processor
// Clock, reset and program loading through the imem port
// Galois LFSR for random registers and immediates
// In-order ISA reference model that predicts every retirement
// Tests for ALU forwarding, load-use, branches, undefined opcode and halt
module proc_tb import procIsa_pkg::*; ();

    logic                 clk;
    logic                 rst;
    logic                 imemWrEn;
    logic [ImemAddrW-1:0] imemWrAddr;
    wordT                 imemWrData;
    logic                 retireValid;
    regAddrT              retireRd;
    wordT                 retireData;
    logic                 retireWrite;
    logic                 halted;
    logic                 err;

    logic [31:0] lfsrState = 32'h5044;
    wordT        prog [$];
    logic [19:0] expQ [$];
    int          errCount = 0;
    int          testCount = 0;
    int          failedTests = 0;

    proc i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int takeBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic wordT encR(input opcodeT op, input int rd, input int rs, input int rt);
        return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
    endfunction

    function automatic wordT encI(input opcodeT op, input int rd, input int rs, input int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    function automatic wordT encB(input opcodeT op, input int r, input int off);
        return {op, r[2:0], off[8:0]};
    endfunction

    function automatic int totalErrors();
        return errCount + i_dut.procChecks.failCount;
    endfunction

    // Walks the program in order and queues {write, rd, data} per retirement
    task automatic modelProgram();
        wordT  regs [8];
        wordT  mdl [256];
        wordT  instr;
        wordT  imm;
        wordT  off;
        wordT  ea;
        wordT  res;
        logic  wr;
        int    pc;
        int    nextPc;
        int    steps;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        expQ.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = 0;
        for (steps = 0; steps < 300; steps++) begin
            if (pc < 0 || pc >= prog.size()) begin
                $display("model ran outside the program at pc %0d", pc);
                errCount++;
                break;
            end
            instr = prog[pc];
            rd = instr[11:9];
            rs = instr[8:6];
            rt = instr[5:3];
            imm = {{10{instr[5]}}, instr[5:0]};
            off = {{7{instr[8]}}, instr[8:0]};
            ea = regs[rs] + imm;
            res = '0;
            wr = 1'b0;
            nextPc = pc + 1;
            case (opcodeT'(instr[15:12]))
                opAdd: begin res = regs[rs] + regs[rt]; wr = 1'b1; end
                opSub: begin res = regs[rs] - regs[rt]; wr = 1'b1; end
                opAnd: begin res = regs[rs] & regs[rt]; wr = 1'b1; end
                opXor: begin res = regs[rs] ^ regs[rt]; wr = 1'b1; end
                opAddi: begin res = ea; wr = 1'b1; end
                opLd: begin res = mdl[ea[7:0]]; wr = 1'b1; end
                opSt: mdl[ea[7:0]] = regs[rd];
                opBeqz: if (regs[rd] == '0) nextPc = pc + 1 + int'(signed'(off));
                opBnez: if (regs[rd] != '0) nextPc = pc + 1 + int'(signed'(off));
                default: wr = 1'b0;
            endcase
            wr = wr && (rd != 3'd0);
            expQ.push_back({wr, wr ? rd : 3'd0, wr ? res : 16'd0});
            if (wr) begin
                regs[rd] = res;
            end
            if (instr[15:12] == opHalt) begin
                break;
            end
            pc = nextPc;
        end
    endtask

    task automatic resetAndLoad();
        @(negedge clk);
        rst = 1'b1;
        foreach (prog[i]) begin
            imemWrEn = 1'b1;
            imemWrAddr = 8'(i);
            imemWrData = prog[i];
            @(negedge clk);
        end
        imemWrEn = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic runTest(input string name, input logic expectErr);
        int          errsBefore;
        int          cycles;
        int          retired;
        logic [19:0] exp;
        logic [19:0] got;
        errsBefore = totalErrors();
        retired = 0;
        modelProgram();
        resetAndLoad();
        assert (!halted && !err) else begin
            $display("%s: halted or err still high after reset", name);
            errCount++;
        end
        cycles = 0;
        while (!halted && cycles < 400) begin
            @(negedge clk);
            cycles++;
            if (retireValid) begin
                retired++;
                got = {retireWrite, retireWrite ? retireRd : 3'd0,
                       retireWrite ? retireData : 16'd0};
                if (expQ.size() == 0) begin
                    $display("%s: retirement after the end of the program", name);
                    errCount++;
                end else begin
                    exp = expQ.pop_front();
                    assert (got == exp) else begin
                        $display("error %s: expected %h actual %h", name, exp, got);
                        errCount++;
                    end
                end
            end
        end
        if (!halted) begin
            $display("%s: timed out waiting for halted", name);
            errCount++;
        end
        // Quiet window after halt
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            assert (!retireValid) else begin
                $display("%s: an instruction retired after halt", name);
                errCount++;
            end
        end
        assert (expQ.size() == 0) else begin
            $display("%s: %0d expected retirements never happened", name, expQ.size());
            errCount++;
        end
        assert (err == expectErr) else begin
            $display("error %s err flag: expected %0b actual %0b", name, expectErr, err);
            errCount++;
        end
        testCount++;
        if (totalErrors() != errsBefore) begin
            failedTests++;
        end
        $display("test %s: %0d retirements, %0d new errors", name, retired,
                 totalErrors() - errsBefore);
    endtask

    task automatic aluProgram();
        int sel;
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            prog.push_back(encI(opAddi, r, 0, takeBits(6)));
        end
        // Fixed chain hitting EX/MEM and MEM/WB forwarding
        prog.push_back(encR(opAdd, 1, 2, 3));
        prog.push_back(encR(opAdd, 4, 1, 1));
        prog.push_back(encR(opSub, 5, 1, 4));
        for (int i = 0; i < 24; i++) begin
            sel = takeBits(3) % 5;
            if (sel == 4) begin
                prog.push_back(encI(opAddi, takeBits(3), takeBits(3), takeBits(6)));
            end else begin
                prog.push_back(encR(opcodeT'(sel[3:0]), takeBits(3), takeBits(3), takeBits(3)));
            end
        end
        prog.push_back(encR(opHalt, 0, 0, 0));
    endtask

    task automatic memProgram();
        prog.delete();
        prog.push_back(encI(opAddi, 1, 0, 12));
        prog.push_back(encI(opAddi, 2, 0, -7));
        prog.push_back(encI(opSt, 2, 1, 3));
        prog.push_back(encI(opLd, 3, 1, 3));
        // Load result used at once
        prog.push_back(encR(opAdd, 4, 3, 3));
        prog.push_back(encR(opXor, 5, 4, 2));
        prog.push_back(encI(opSt, 5, 1, 0));
        prog.push_back(encI(opLd, 6, 1, 0));
        prog.push_back(encR(opSub, 7, 2, 6));
        prog.push_back(encR(opHalt, 0, 0, 0));
    endtask

    task automatic branchProgram();
        prog.delete();
        prog.push_back(encI(opAddi, 1, 0, 0));
        prog.push_back(encI(opAddi, 2, 0, 3));
        prog.push_back(encB(opBeqz, 1, 2));
        prog.push_back(encI(opAddi, 3, 0, 1));
        prog.push_back(encI(opAddi, 4, 0, 1));
        prog.push_back(encB(opBnez, 2, 2));
        prog.push_back(encI(opAddi, 3, 0, 2));
        prog.push_back(encI(opAddi, 4, 0, 2));
        prog.push_back(encB(opBeqz, 2, 5));
        prog.push_back(encI(opAddi, 5, 0, 9));
        // Countdown loop back to the ADDI
        prog.push_back(encI(opAddi, 2, 2, -1));
        prog.push_back(encB(opBnez, 2, -2));
        prog.push_back(encR(opHalt, 0, 0, 0));
    endtask

    task automatic undefProgram();
        prog.delete();
        prog.push_back(encI(opAddi, 1, 0, 4));
        prog.push_back(16'hB123);
        prog.push_back(encI(opAddi, 2, 1, 1));
        prog.push_back(encR(opHalt, 0, 0, 0));
    endtask

    task automatic haltProgram();
        prog.delete();
        prog.push_back(encI(opAddi, 1, 0, 5));
        prog.push_back(encR(opHalt, 0, 0, 0));
        prog.push_back(encI(opAddi, 2, 0, 1));
        prog.push_back(encI(opAddi, 3, 0, 1));
    endtask

    initial begin
        rst = 1'b1;
        imemWrEn = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        aluProgram();
        runTest("alu", 1'b0);
        memProgram();
        runTest("memory", 1'b0);
        branchProgram();
        runTest("branch", 1'b0);
        undefProgram();
        runTest("undefined opcode", 1'b1);
        // Also shows err cleared by the reset
        haltProgram();
        runTest("halt", 1'b0);
        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, totalErrors());
        if (totalErrors() == 0 && failedTests == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: proc.f
procIsa_pkg.sv
procPipe_pkg.sv
fetch.sv
decode.sv
pipeControl.sv
execute.sv
memStage.sv
proc.sv
proc_assert.sv
proc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= proc_tb
FILELIST  ?= proc.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
